/* uce_top.f */
hw/uce_cache_pkg.sv
hw/uce_mem_pkg.sv
hw/uce_credit_counter.sv
hw/uce_fill.sv
hw/uce_ctrl.sv
hw/uce_top.sv
tb/uce_tb.sv

/* Bender.yml */
package:
  name: uce

sources:
  - hw/uce_cache_pkg.sv
  - hw/uce_mem_pkg.sv
  - hw/uce_credit_counter.sv
  - hw/uce_fill.sv
  - hw/uce_ctrl.sv
  - hw/uce_top.sv
  - target: simulation
    files:
      - tb/uce_tb.sv

/* tb/uce_tb.sv */
`timescale 1ns/1ps

module uce_tb;

  localparam int clk_period_lp    = 40;
  localparam int num_entries_lp   = 10;
  localparam int entry_cycles_lp  = 300;
  localparam int credit_stores_lp = 4;
  localparam uce_mem_pkg::lce_id_t lce_id_lp = 4'h9;

  // one request and the memory command type that it must produce
  typedef struct packed
  {
    uce_cache_pkg::cache_req_s req;
    uce_mem_pkg::mem_msg_e     cmd_type;
  } stim_entry_s;

  logic clk_i, reset_i;
  uce_mem_pkg::lce_id_t lce_id;
  uce_cache_pkg::cache_req_s cache_req;
  logic cache_req_v, cache_req_yumi, busy, complete, crit_tag, crit_data;
  logic credits_full, credits_empty;
  uce_cache_pkg::tag_mem_pkt_s tag_pkt;
  uce_cache_pkg::data_mem_pkt_s data_pkt;
  logic tag_v, tag_yumi, data_v, data_yumi;
  uce_mem_pkg::mem_msg_s mem_cmd, mem_resp;
  logic mem_cmd_v, mem_cmd_yumi, mem_resp_v, mem_resp_yumi;

  uce_mem_pkg::mem_msg_s exp_cmd_q[$];
  uce_mem_pkg::mem_msg_s resp_q[$];
  uce_cache_pkg::tag_mem_pkt_s exp_tag_q[$];
  uce_cache_pkg::data_mem_pkt_s exp_data_q[$];
  stim_entry_s stim_table [num_entries_lp];

  logic [31:0] rng_state;
  logic bp_en, resp_hold, resp_taken;
  logic [1:0] resp_wait;
  int complete_cnt, crit_tag_cnt, crit_data_cnt;
  int exp_complete, exp_crit_tag, exp_crit_data;

  uce_top #(.credits_p(4)) i_dut
  (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .lce_id_i                  (lce_id),
    .cache_req_i               (cache_req),
    .cache_req_v_i             (cache_req_v),
    .cache_req_yumi_o          (cache_req_yumi),
    .cache_req_busy_o          (busy),
    .cache_req_complete_o      (complete),
    .cache_req_critical_tag_o  (crit_tag),
    .cache_req_critical_data_o (crit_data),
    .cache_req_credits_full_o  (credits_full),
    .cache_req_credits_empty_o (credits_empty),
    .tag_mem_pkt_o             (tag_pkt),
    .tag_mem_pkt_v_o           (tag_v),
    .tag_mem_pkt_yumi_i        (tag_yumi),
    .data_mem_pkt_o            (data_pkt),
    .data_mem_pkt_v_o          (data_v),
    .data_mem_pkt_yumi_i       (data_yumi),
    .mem_cmd_o                 (mem_cmd),
    .mem_cmd_v_o               (mem_cmd_v),
    .mem_cmd_yumi_i            (mem_cmd_yumi),
    .mem_resp_i                (mem_resp),
    .mem_resp_v_i              (mem_resp_v),
    .mem_resp_yumi_o           (mem_resp_yumi)
  );

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every dword of a block carries the full address and its own position
  function automatic uce_cache_pkg::block_t block_pattern(input uce_cache_pkg::paddr_t addr);
    uce_cache_pkg::block_t blk;
    for (int i = 0; i < 8; i++)
      blk[64*i +: 64] = {addr, 8'(i), 16'h3c5a};
    return blk;
  endfunction

  function automatic stim_entry_s make_entry(input uce_cache_pkg::cache_msg_e kind,
                                             input uce_cache_pkg::paddr_t addr,
                                             input logic [1:0] size,
                                             input uce_cache_pkg::dword_t data,
                                             input uce_cache_pkg::way_t way,
                                             input uce_mem_pkg::mem_msg_e cmd_type);
    stim_entry_s e;
    e.req.msg_type = kind;
    e.req.addr     = addr;
    e.req.size     = size;
    e.req.data     = data;
    e.req.repl_way = way;
    e.cmd_type     = cmd_type;
    return e;
  endfunction

  function automatic uce_mem_pkg::mem_msg_s expected_cmd(input stim_entry_s e);
    uce_mem_pkg::mem_msg_s cmd;
    cmd          = '0;
    cmd.msg_type = e.cmd_type;
    cmd.lce_id   = lce_id_lp;
    if (e.cmd_type == uce_mem_pkg::e_mem_rd)
    begin
      cmd.addr   = {e.req.addr[39:6], 6'b0};
      cmd.size   = uce_mem_pkg::e_size_64;
      cmd.way_id = e.req.repl_way;
    end
    else
    begin
      cmd.addr = e.req.addr;
      cmd.size = uce_mem_pkg::mem_size_e'({1'b0, e.req.size});
    end
    if (e.cmd_type == uce_mem_pkg::e_mem_uc_wr)
      cmd.data[63:0] = e.req.data;
    return cmd;
  endfunction

  function automatic uce_mem_pkg::mem_msg_s make_resp(input uce_mem_pkg::mem_msg_s cmd);
    uce_mem_pkg::mem_msg_s resp;
    resp      = cmd;
    resp.data = '0;
    if (cmd.msg_type inside {uce_mem_pkg::e_mem_rd, uce_mem_pkg::e_mem_uc_rd})
      resp.data = block_pattern(cmd.addr);
    return resp;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [639:0] got,
                                input logic [639:0] exp);
    $display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic expect_clear;
    uce_cache_pkg::tag_mem_pkt_s pkt;
    for (int i = 0; i < uce_cache_pkg::num_sets; i++)
    begin
      pkt        = '0;
      pkt.opcode = uce_cache_pkg::e_tag_set_clear;
      pkt.index  = uce_cache_pkg::index_t'(i);
      pkt.state  = uce_cache_pkg::e_coh_i;
      exp_tag_q.push_back(pkt);
    end
  endtask

  task automatic drive_req(input stim_entry_s e);
    uce_cache_pkg::tag_mem_pkt_s tpkt;
    uce_cache_pkg::data_mem_pkt_s dpkt;
    uce_cache_pkg::paddr_t blk_addr;
    uce_cache_pkg::block_t uc_blk;
    @(posedge clk_i);
    #1;
    blk_addr = {e.req.addr[39:6], 6'b0};
    tpkt     = '0;
    dpkt     = '0;
    case (e.req.msg_type)
      uce_cache_pkg::e_cache_clear:
        expect_clear();
      uce_cache_pkg::e_uc_load:
      begin
        uc_blk      = block_pattern(e.req.addr);
        dpkt.opcode = uce_cache_pkg::e_data_uncached;
        dpkt.data   = {8{uc_blk[63:0]}};
        exp_data_q.push_back(dpkt);
        exp_crit_data++;
      end
      uce_cache_pkg::e_miss_load, uce_cache_pkg::e_miss_store:
      begin
        tpkt.opcode = uce_cache_pkg::e_tag_set_tag;
        tpkt.index  = e.req.addr[11:6];
        tpkt.way_id = e.req.repl_way;
        tpkt.state  = uce_cache_pkg::e_coh_m;
        tpkt.tag    = e.req.addr[39:12];
        exp_tag_q.push_back(tpkt);
        dpkt.opcode = uce_cache_pkg::e_data_write;
        dpkt.index  = e.req.addr[11:6];
        dpkt.way_id = e.req.repl_way;
        dpkt.data   = block_pattern(blk_addr);
        exp_data_q.push_back(dpkt);
        exp_crit_tag++;
        exp_crit_data++;
      end
      default:
        ;
    endcase
    if (e.req.msg_type != uce_cache_pkg::e_cache_clear)
      exp_cmd_q.push_back(expected_cmd(e));
    exp_complete++;
    cache_req   = e.req;
    cache_req_v = 1'b1;
  endtask

  task automatic await_done(input stim_entry_s e);
    logic taken, done, is_clear, is_store, fills;
    taken    = 1'b0;
    done     = 1'b0;
    is_clear = (e.req.msg_type == uce_cache_pkg::e_cache_clear);
    is_store = e.req.msg_type inside {uce_cache_pkg::e_uc_store, uce_cache_pkg::e_wt_store};
    fills    = e.req.msg_type inside {uce_cache_pkg::e_uc_load, uce_cache_pkg::e_miss_load,
                                      uce_cache_pkg::e_miss_store};
    while (!done)
    begin
      @(negedge clk_i);
      if (is_clear && taken)
      begin
        assert (busy) else abort_run("busy dropped while the tag sets were being cleared");
      end
      if (cache_req_yumi)
      begin
        assert (!taken) else abort_run("the same request was taken twice");
        taken = 1'b1;
      end
      if (complete)
      begin
        assert (taken) else abort_run("complete pulsed before the request was taken");
        assert (crit_data == fills)
          else value_mismatch("cache_req_critical_data_o", crit_data, fills);
        if (is_store)
        begin
          assert (mem_cmd_v && mem_cmd_yumi)
            else abort_run("a store completed outside the cycle its command was accepted");
        end
        done = 1'b1;
      end
      if (taken && cache_req_v)
      begin
        @(posedge clk_i);
        #1;
        cache_req_v = 1'b0;
      end
    end
    if (is_clear)
    begin
      @(negedge clk_i);
      assert (!busy) else abort_run("busy still high after the clear completed");
      assert (exp_tag_q.size() == 0)
        else abort_run("the clear ended before every set was cleared");
    end
  endtask

  task automatic check_reset_clear;
    logic done;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk_i);
      assert (busy) else abort_run("busy low during the clear after reset");
      done = complete;
    end
    @(negedge clk_i);
    assert (!busy) else abort_run("busy still high after the reset clear");
    assert (exp_tag_q.size() == 0) else abort_run("the reset clear missed some sets");
  endtask

  // waits until every command has been answered and no response is left
  task automatic drain;
    logic idle;
    idle = 1'b0;
    while (!idle)
    begin
      @(negedge clk_i);
      idle = !mem_cmd_v && !mem_resp_v && (resp_q.size() == 0);
    end
    assert (credits_empty)
      else value_mismatch("cache_req_credits_empty_o", credits_empty, 1'b1);
    assert (exp_cmd_q.size() == 0 && exp_tag_q.size() == 0 && exp_data_q.size() == 0)
      else abort_run("some expected commands or packets never appeared");
  endtask

  task automatic run_credit_limit;
    stim_entry_s e;
    bp_en     = 1'b0;
    resp_hold = 1'b1;
    for (int i = 0; i <= credit_stores_lp; i++)
    begin
      e = make_entry(uce_cache_pkg::e_uc_store, 40'h00_4000_0000 + 40'(i * 8), 2'd3,
                     {32'(32'ha5a5_0000 + i), 32'(i)}, 3'd0, uce_mem_pkg::e_mem_uc_wr);
      drive_req(e);
      if (i == credit_stores_lp)
      begin
        repeat (3)
        begin
          @(negedge clk_i);
          assert (credits_full && busy && !mem_cmd_v && !cache_req_yumi)
            else abort_run("a store went out while all credits were in use");
        end
        resp_hold = 1'b0;
      end
      await_done(e);
    end
  endtask

  // yumi gating and the memory responder share one random stream
  always @(posedge clk_i)
  begin
    #1;
    rng_state    = next_random(rng_state);
    tag_yumi     = bp_en ? rng_state[0] : 1'b1;
    data_yumi    = bp_en ? rng_state[1] : 1'b1;
    mem_cmd_yumi = bp_en ? rng_state[2] : 1'b1;
    if (resp_taken)
    begin
      resp_taken = 1'b0;
      mem_resp_v = 1'b0;
      void'(resp_q.pop_front());
      resp_wait  = rng_state[9:8];
    end
    else if (!mem_resp_v && (resp_q.size() > 0) && !resp_hold)
    begin
      if (resp_wait == 0)
      begin
        mem_resp   = resp_q[0];
        mem_resp_v = 1'b1;
      end
      else
        resp_wait = resp_wait - 1'b1;
    end
  end

  always @(negedge clk_i)
  begin
    if (reset_i)
    begin
      assert (!tag_v && !data_v && !mem_cmd_v && !cache_req_yumi && !mem_resp_yumi
              && !complete && !crit_tag && !crit_data && busy)
        else abort_run("outputs were not idle with busy high during reset");
    end
    if (mem_cmd_v && mem_cmd_yumi)
    begin
      assert (exp_cmd_q.size() > 0) else abort_run("a memory command came with none expected");
      assert (mem_cmd == exp_cmd_q[0]) else value_mismatch("mem_cmd_o", mem_cmd, exp_cmd_q[0]);
      void'(exp_cmd_q.pop_front());
      resp_q.push_back(make_resp(mem_cmd));
    end
    if (tag_v && tag_yumi)
    begin
      assert (exp_tag_q.size() > 0) else abort_run("a tag packet came with none expected");
      assert (tag_pkt == exp_tag_q[0]) else value_mismatch("tag_mem_pkt_o", tag_pkt, exp_tag_q[0]);
      void'(exp_tag_q.pop_front());
    end
    if (data_v && data_yumi)
    begin
      assert (exp_data_q.size() > 0) else abort_run("a data packet came with none expected");
      assert (data_pkt == exp_data_q[0])
        else value_mismatch("data_mem_pkt_o", data_pkt, exp_data_q[0]);
      void'(exp_data_q.pop_front());
    end
    if (mem_resp_v && mem_resp.msg_type == uce_mem_pkg::e_mem_uc_wr)
    begin
      assert (mem_resp_yumi) else abort_run("a store response was not acknowledged at once");
    end
    assert (mem_resp_v || !mem_resp_yumi)
      else abort_run("a response was acknowledged while none was valid");
    if (mem_resp_v && mem_resp_yumi)
      resp_taken = 1'b1;
    complete_cnt  += complete;
    crit_tag_cnt  += crit_tag;
    crit_data_cnt += crit_data;
  end

  initial
  begin
    #(clk_period_lp * entry_cycles_lp * (2 * num_entries_lp + credit_stores_lp + 2));
    abort_run("watchdog expired before the tests finished");
  end

  initial
  begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    lce_id       = lce_id_lp;
    cache_req    = '0;
    cache_req_v  = 1'b0;
    tag_yumi     = 1'b0;
    data_yumi    = 1'b0;
    mem_cmd_yumi = 1'b0;
    mem_resp     = '0;
    mem_resp_v   = 1'b0;
    rng_state    = 32'h719244fa;
    bp_en        = 1'b0;
    resp_hold    = 1'b0;
    resp_taken   = 1'b0;
    resp_wait    = '0;
    complete_cnt  = 0;
    crit_tag_cnt  = 0;
    crit_data_cnt = 0;
    exp_crit_tag  = 0;
    exp_crit_data = 0;

    stim_table[0] = make_entry(uce_cache_pkg::e_uc_store, 40'h00_1234_5678, 2'd3,
                               64'h0123_4567_89ab_cdef, 3'd0, uce_mem_pkg::e_mem_uc_wr);
    stim_table[1] = make_entry(uce_cache_pkg::e_wt_store, 40'h80_0000_0104, 2'd2,
                               64'h0000_0000_7e57_d00d, 3'd0, uce_mem_pkg::e_mem_uc_wr);
    stim_table[2] = make_entry(uce_cache_pkg::e_uc_load, 40'h10_0000_0008, 2'd3,
                               64'h0, 3'd0, uce_mem_pkg::e_mem_uc_rd);
    stim_table[3] = make_entry(uce_cache_pkg::e_miss_load, 40'h00_0abc_d040, 2'd3,
                               64'h0, 3'd2, uce_mem_pkg::e_mem_rd);
    stim_table[4] = make_entry(uce_cache_pkg::e_miss_store, 40'hff_ffff_ffc8, 2'd3,
                               64'h5555_aaaa_5555_aaaa, 3'd5, uce_mem_pkg::e_mem_rd);
    stim_table[5] = make_entry(uce_cache_pkg::e_wt_store, 40'h00_0000_0001, 2'd0,
                               64'h0000_0000_0000_00a7, 3'd0, uce_mem_pkg::e_mem_uc_wr);
    stim_table[6] = make_entry(uce_cache_pkg::e_cache_clear, 40'h0, 2'd0,
                               64'h0, 3'd0, uce_mem_pkg::e_mem_wr);
    stim_table[7] = make_entry(uce_cache_pkg::e_uc_load, 40'h3c_0000_0f04, 2'd2,
                               64'h0, 3'd0, uce_mem_pkg::e_mem_uc_rd);
    stim_table[8] = make_entry(uce_cache_pkg::e_miss_load, 40'h01_2345_67bf, 2'd1,
                               64'h0, 3'd7, uce_mem_pkg::e_mem_rd);
    stim_table[9] = make_entry(uce_cache_pkg::e_uc_store, 40'h7f_fff0_0000, 2'd1,
                               64'h0000_0000_0000_b00c, 3'd0, uce_mem_pkg::e_mem_uc_wr);

    // the clear after reset is expected before reset is released
    expect_clear();
    exp_complete = 1;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_reset_clear();

    // the second pass runs the same table under random back-pressure
    for (int pass = 0; pass < 2; pass++)
    begin
      bp_en = (pass == 1);
      for (int i = 0; i < num_entries_lp; i++)
      begin
        drive_req(stim_table[i]);
        await_done(stim_table[i]);
      end
      drain();
    end

    run_credit_limit();
    drain();

    assert (complete_cnt == exp_complete)
      else value_mismatch("cache_req_complete_o pulses", complete_cnt, exp_complete);
    assert (crit_tag_cnt == exp_crit_tag)
      else value_mismatch("cache_req_critical_tag_o pulses", crit_tag_cnt, exp_crit_tag);
    assert (crit_data_cnt == exp_crit_data)
      else value_mismatch("cache_req_critical_data_o pulses", crit_data_cnt, exp_crit_data);
    $display("sim passed");
    $finish;
  end

endmodule

/* hw/uce_top.sv */
`timescale 1ns/1ps

module uce_top
#(
  parameter int credits_p = 4
)
(
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  uce_mem_pkg::lce_id_t         lce_id_i,

  input  uce_cache_pkg::cache_req_s    cache_req_i,
  input  logic                         cache_req_v_i,
  output logic                         cache_req_yumi_o,
  output logic                         cache_req_busy_o,
  output logic                         cache_req_complete_o,
  output logic                         cache_req_critical_tag_o,
  output logic                         cache_req_critical_data_o,

  output logic                         cache_req_credits_full_o,
  output logic                         cache_req_credits_empty_o,

  output uce_cache_pkg::tag_mem_pkt_s  tag_mem_pkt_o,
  output logic                         tag_mem_pkt_v_o,
  input  logic                         tag_mem_pkt_yumi_i,

  output uce_cache_pkg::data_mem_pkt_s data_mem_pkt_o,
  output logic                         data_mem_pkt_v_o,
  input  logic                         data_mem_pkt_yumi_i,

  output uce_mem_pkg::mem_msg_s        mem_cmd_o,
  output logic                         mem_cmd_v_o,
  input  logic                         mem_cmd_yumi_i,

  input  uce_mem_pkg::mem_msg_s        mem_resp_i,
  input  logic                         mem_resp_v_i,
  output logic                         mem_resp_yumi_o
);

  uce_cache_pkg::tag_mem_pkt_s ctrl_tag_pkt, fill_tag_pkt;
  logic ctrl_tag_v, fill_tag_v;
  logic fill_en, fill_done;

  uce_ctrl i_ctrl
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .lce_id_i         (lce_id_i),
    .cache_req_i      (cache_req_i),
    .cache_req_v_i    (cache_req_v_i),
    .credits_full_i   (cache_req_credits_full_o),
    .tag_mem_yumi_i   (tag_mem_pkt_yumi_i),
    .mem_cmd_yumi_i   (mem_cmd_yumi_i),
    .fill_done_i      (fill_done),
    .cache_req_yumi_o (cache_req_yumi_o),
    .busy_o           (cache_req_busy_o),
    .complete_o       (cache_req_complete_o),
    .tag_mem_pkt_o    (ctrl_tag_pkt),
    .tag_mem_pkt_v_o  (ctrl_tag_v),
    .mem_cmd_o        (mem_cmd_o),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .fill_en_o        (fill_en)
  );

  uce_fill i_fill
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fill_en_i        (fill_en),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_v_i     (mem_resp_v_i),
    .tag_mem_yumi_i   (tag_mem_pkt_yumi_i),
    .data_mem_yumi_i  (data_mem_pkt_yumi_i),
    .tag_mem_pkt_o    (fill_tag_pkt),
    .tag_mem_pkt_v_o  (fill_tag_v),
    .data_mem_pkt_o   (data_mem_pkt_o),
    .data_mem_pkt_v_o (data_mem_pkt_v_o),
    .mem_resp_yumi_o  (mem_resp_yumi_o),
    .fill_done_o      (fill_done),
    .critical_tag_o   (cache_req_critical_tag_o),
    .critical_data_o  (cache_req_critical_data_o)
  );

  uce_credit_counter #(.credits_p(credits_p)) i_credit_counter
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_accept_i  (mem_cmd_v_o & mem_cmd_yumi_i),
    .resp_accept_i (mem_resp_yumi_o),
    .full_o        (cache_req_credits_full_o),
    .empty_o       (cache_req_credits_empty_o)
  );

  // clear packets and fill packets are never offered in the same cycle
  assign tag_mem_pkt_o   = ctrl_tag_v ? ctrl_tag_pkt : fill_tag_pkt;
  assign tag_mem_pkt_v_o = ctrl_tag_v | fill_tag_v;

endmodule

/* hw/uce_ctrl.sv */
`timescale 1ns/1ps

module uce_ctrl
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  uce_mem_pkg::lce_id_t        lce_id_i,
  input  uce_cache_pkg::cache_req_s   cache_req_i,
  input  logic                        cache_req_v_i,
  input  logic                        credits_full_i,
  input  logic                        tag_mem_yumi_i,
  input  logic                        mem_cmd_yumi_i,
  input  logic                        fill_done_i,
  output logic                        cache_req_yumi_o,
  output logic                        busy_o,
  output logic                        complete_o,
  output uce_cache_pkg::tag_mem_pkt_s tag_mem_pkt_o,
  output logic                        tag_mem_pkt_v_o,
  output uce_mem_pkg::mem_msg_s       mem_cmd_o,
  output logic                        mem_cmd_v_o,
  output logic                        fill_en_o
);

  typedef enum logic [2:0]
  {
    e_reset,
    e_clear,
    e_ready,
    e_send,
    e_wait
  } uce_state_e;

  uce_state_e state_r, state_n;
  uce_cache_pkg::cache_req_s req_r;
  uce_cache_pkg::index_t index_r;
  logic store_v, clear_v, index_up, index_done;

  // misses fetch the whole block, everything else goes out uncached
  function automatic uce_mem_pkg::mem_msg_s form_cmd(input uce_cache_pkg::cache_req_s req,
                                                     input uce_mem_pkg::lce_id_t lce_id);
    uce_mem_pkg::mem_msg_s cmd;

    cmd        = '0;
    cmd.lce_id = lce_id;
    cmd.addr   = req.addr;
    cmd.size   = uce_mem_pkg::mem_size_e'({1'b0, req.size});
    case (req.msg_type)
      uce_cache_pkg::e_miss_load, uce_cache_pkg::e_miss_store:
      begin
        cmd.msg_type = uce_mem_pkg::e_mem_rd;
        cmd.addr[uce_cache_pkg::block_offset_width-1:0] = '0;
        cmd.size   = uce_mem_pkg::e_size_64;
        cmd.way_id = req.repl_way;
      end
      uce_cache_pkg::e_uc_load:
        cmd.msg_type = uce_mem_pkg::e_mem_uc_rd;
      default:
      begin
        cmd.msg_type = uce_mem_pkg::e_mem_uc_wr;
        cmd.data[$bits(uce_cache_pkg::dword_t)-1:0] = req.data;
      end
    endcase
    return cmd;
  endfunction

  assign store_v = cache_req_i.msg_type inside {uce_cache_pkg::e_uc_store,
                                                uce_cache_pkg::e_wt_store};
  assign clear_v = (cache_req_i.msg_type == uce_cache_pkg::e_cache_clear);

  // stores leave straight from the request port, the rest from the captured copy
  assign mem_cmd_o = form_cmd((state_r == e_ready) ? cache_req_i : req_r, lce_id_i);

  assign index_done = (index_r == uce_cache_pkg::index_t'(uce_cache_pkg::num_sets - 1));

  always_comb
  begin
    tag_mem_pkt_o    = '0;
    tag_mem_pkt_o.opcode = uce_cache_pkg::e_tag_set_clear;
    tag_mem_pkt_o.index  = index_r;
    tag_mem_pkt_o.state  = uce_cache_pkg::e_coh_i;
  end

  assign busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full_i;

  always_comb
  begin
    state_n          = state_r;
    cache_req_yumi_o = 1'b0;
    complete_o       = 1'b0;
    tag_mem_pkt_v_o  = 1'b0;
    mem_cmd_v_o      = 1'b0;
    fill_en_o        = 1'b0;
    index_up         = 1'b0;
    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_mem_pkt_v_o = 1'b1;
        index_up        = tag_mem_yumi_i;
        complete_o      = index_up & index_done;
        if (complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        if (cache_req_v_i & store_v)
        begin
          // the store is taken only once memory takes its command
          mem_cmd_v_o      = ~credits_full_i;
          complete_o       = mem_cmd_v_o & mem_cmd_yumi_i;
          cache_req_yumi_o = mem_cmd_v_o & mem_cmd_yumi_i;
        end
        else if (cache_req_v_i)
        begin
          cache_req_yumi_o = 1'b1;
          state_n          = clear_v ? e_clear : e_send;
        end
      end
      e_send:
      begin
        mem_cmd_v_o = ~credits_full_i;
        if (mem_cmd_v_o & mem_cmd_yumi_i)
          state_n = e_wait;
      end
      e_wait:
      begin
        fill_en_o  = 1'b1;
        complete_o = fill_done_i;
        if (fill_done_i)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      index_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      // wraps back to zero after the last set, ready for the next clear
      if (index_up)
        index_r <= index_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_o)
      req_r <= cache_req_i;
  end

endmodule

/* hw/uce_fill.sv */
`timescale 1ns/1ps

module uce_fill
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         fill_en_i,
  input  uce_mem_pkg::mem_msg_s        mem_resp_i,
  input  logic                         mem_resp_v_i,
  input  logic                         tag_mem_yumi_i,
  input  logic                         data_mem_yumi_i,
  output uce_cache_pkg::tag_mem_pkt_s  tag_mem_pkt_o,
  output logic                         tag_mem_pkt_v_o,
  output uce_cache_pkg::data_mem_pkt_s data_mem_pkt_o,
  output logic                         data_mem_pkt_v_o,
  output logic                         mem_resp_yumi_o,
  output logic                         fill_done_o,
  output logic                         critical_tag_o,
  output logic                         critical_data_o
);

  localparam int tag_lsb_lp = uce_cache_pkg::block_offset_width + $bits(uce_cache_pkg::index_t);
  localparam int dwords_lp  = $bits(uce_cache_pkg::block_t) / $bits(uce_cache_pkg::dword_t);

  logic store_resp_v, block_resp_v, uc_resp_v;
  logic tag_acc, data_acc;
  logic tag_sent_r, data_sent_r;
  uce_cache_pkg::index_t resp_index;

  assign store_resp_v = mem_resp_v_i
    & (mem_resp_i.msg_type inside {uce_mem_pkg::e_mem_wr, uce_mem_pkg::e_mem_uc_wr});
  assign block_resp_v = fill_en_i & mem_resp_v_i & (mem_resp_i.msg_type == uce_mem_pkg::e_mem_rd);
  assign uc_resp_v = fill_en_i & mem_resp_v_i & (mem_resp_i.msg_type == uce_mem_pkg::e_mem_uc_rd);

  assign resp_index = mem_resp_i.addr[uce_cache_pkg::block_offset_width +: 6];

  always_comb
  begin
    tag_mem_pkt_o        = '0;
    tag_mem_pkt_o.opcode = uce_cache_pkg::e_tag_set_tag;
    tag_mem_pkt_o.index  = resp_index;
    tag_mem_pkt_o.way_id = mem_resp_i.way_id;
    tag_mem_pkt_o.state  = uce_cache_pkg::e_coh_m;
    tag_mem_pkt_o.tag    = mem_resp_i.addr[tag_lsb_lp +: $bits(uce_cache_pkg::tag_t)];
  end

  always_comb
  begin
    data_mem_pkt_o = '0;
    if (uc_resp_v)
    begin
      data_mem_pkt_o.opcode = uce_cache_pkg::e_data_uncached;
      data_mem_pkt_o.data   = {dwords_lp{mem_resp_i.data[0 +: $bits(uce_cache_pkg::dword_t)]}};
    end
    else
    begin
      data_mem_pkt_o.opcode = uce_cache_pkg::e_data_write;
      data_mem_pkt_o.index  = resp_index;
      data_mem_pkt_o.way_id = mem_resp_i.way_id;
      data_mem_pkt_o.data   = mem_resp_i.data;
    end
  end

  // a memory that already took its half of the fill is not offered the packet again
  assign tag_mem_pkt_v_o  = block_resp_v & ~tag_sent_r;
  assign data_mem_pkt_v_o = (block_resp_v & ~data_sent_r) | uc_resp_v;

  assign tag_acc  = tag_mem_pkt_v_o & tag_mem_yumi_i;
  assign data_acc = data_mem_pkt_v_o & data_mem_yumi_i;

  assign fill_done_o = (block_resp_v & (tag_sent_r | tag_acc) & (data_sent_r | data_acc))
    | (uc_resp_v & data_acc);

  assign mem_resp_yumi_o = store_resp_v | fill_done_o;
  assign critical_tag_o  = tag_acc;
  assign critical_data_o = fill_done_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tag_sent_r  <= 1'b0;
      data_sent_r <= 1'b0;
    end
    else if (fill_done_o)
    begin
      tag_sent_r  <= 1'b0;
      data_sent_r <= 1'b0;
    end
    else
    begin
      tag_sent_r  <= tag_sent_r | tag_acc;
      data_sent_r <= data_sent_r | data_acc;
    end
  end

endmodule

/* hw/uce_credit_counter.sv */
`timescale 1ns/1ps

module uce_credit_counter
#(
  parameter int credits_p = 4
)
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cmd_accept_i,
  input  logic resp_accept_i,
  output logic full_o,
  output logic empty_o
);

  localparam int cnt_width_lp = $clog2(credits_p + 1);

  typedef logic [cnt_width_lp-1:0] credit_cnt_t;

  credit_cnt_t count_r;

  // a command and a response in the same cycle leave the count unchanged
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (cmd_accept_i & ~resp_accept_i)
      count_r <= count_r + 1'b1;
    else if (~cmd_accept_i & resp_accept_i)
      count_r <= count_r - 1'b1;
  end

  assign full_o  = (count_r == credit_cnt_t'(credits_p));
  assign empty_o = (count_r == '0);

endmodule

/* hw/uce_mem_pkg.sv */
package uce_mem_pkg;

  typedef logic [3:0] lce_id_t;

  typedef enum logic [3:0]
  {
    e_mem_rd    = 4'b0000,
    e_mem_wr    = 4'b0001,
    e_mem_uc_rd = 4'b0010,
    e_mem_uc_wr = 4'b0011
  } mem_msg_e;

  // encoded as log2 of the transfer size in bytes
  typedef enum logic [2:0]
  {
    e_size_1  = 3'b000,
    e_size_2  = 3'b001,
    e_size_4  = 3'b010,
    e_size_8  = 3'b011,
    e_size_64 = 3'b110
  } mem_size_e;

  // the same message is used for commands and responses
  typedef struct packed
  {
    mem_msg_e              msg_type;
    uce_cache_pkg::paddr_t addr;
    mem_size_e             size;
    lce_id_t               lce_id;
    uce_cache_pkg::way_t   way_id;
    uce_cache_pkg::block_t data;
  } mem_msg_s;

endpackage

/* hw/uce_cache_pkg.sv */
package uce_cache_pkg;

  // physical address is split into tag, set index and block offset
  typedef logic [39:0]  paddr_t;
  typedef logic [27:0]  tag_t;
  typedef logic [5:0]   index_t;
  typedef logic [2:0]   way_t;
  typedef logic [63:0]  dword_t;
  typedef logic [511:0] block_t;

  localparam int num_sets           = 64;
  localparam int block_offset_width = 6;

  typedef enum logic [2:0]
  {
    e_miss_load   = 3'b000,
    e_miss_store  = 3'b001,
    e_uc_load     = 3'b010,
    e_uc_store    = 3'b011,
    e_wt_store    = 3'b100,
    e_cache_clear = 3'b101
  } cache_msg_e;

  // size is log2 of the access width in bytes
  typedef struct packed
  {
    cache_msg_e     msg_type;
    paddr_t         addr;
    logic [1:0]     size;
    dword_t         data;
    way_t           repl_way;
  } cache_req_s;

  typedef enum logic [1:0]
  {
    e_tag_set_clear = 2'b00,
    e_tag_set_tag   = 2'b01
  } tag_op_e;

  typedef enum logic [2:0]
  {
    e_coh_i = 3'b000,
    e_coh_m = 3'b111
  } coh_state_e;

  typedef struct packed
  {
    tag_op_e    opcode;
    index_t     index;
    way_t       way_id;
    coh_state_e state;
    tag_t       tag;
  } tag_mem_pkt_s;

  // uncached packets carry no index or way, the cache picks the dword out of the block
  typedef enum logic [1:0]
  {
    e_data_write    = 2'b00,
    e_data_uncached = 2'b01
  } data_op_e;

  typedef struct packed
  {
    data_op_e opcode;
    index_t   index;
    way_t     way_id;
    block_t   data;
  } data_mem_pkt_s;

endpackage
